/* capture_pkg.sv */
package capture_pkg;

  // upper eight bits of one camera pixel
  typedef logic [7:0] pixel_byte_t;

  // flash byte address
  typedef logic [31:0] flash_addr_t;

  // length of one program command in bytes
  typedef logic [31:0] byte_count_t;

  // page inside a line
  typedef logic [3:0] page_idx_t;

  // line count, within a frame or within a phase
  typedef logic [7:0] line_idx_t;

  // interleave phase
  typedef logic [3:0] phase_idx_t;

  // capture sequencer states
  typedef enum logic [3:0] {
    idle,
    wip_wait_poll,
    wip_poll,
    wip_check,
    wait_frame,
    wren,
    wel_poll,
    wel_check,
    page_ready_wait,
    page_program,
    pp_poll,
    pp_check,
    advance
  } seq_state_t;

endpackage

/* flash_pkg.sv */
package flash_pkg;

  // command levels toward the flash spi engine
  typedef struct packed {
    logic wren;
    logic rdsr1;
    logic pp3;
  } cmd_req_t;

  // one spi master's outgoing lines
  typedef struct packed {
    logic sck;
    logic cs;
    logic si;
  } spi_lines_t;

  // status register 1 byte
  typedef logic [7:0] status_t;

  // sr1 bit positions
  localparam int sr_wip_bit = 0;
  localparam int sr_wel_bit = 1;

  // host byte that starts a capture, not a flash opcode
  localparam logic [7:0] take_picture_code = 8'hFF;

endpackage

/* flash_bus_arbiter.sv */
module flash_bus_arbiter
  import flash_pkg::*;
(
  input  logic       flash_mem_interface_done,
  input  logic       camera_1_FV,
  input  logic       take_bus,
  input  spi_lines_t host_spi,
  input  spi_lines_t engine_spi,
  input  logic       flash_so,
  output spi_lines_t flash_spi,
  output logic       host_miso,
  output logic       engine_miso,
  input  logic       engine_done,
  input  status_t    engine_rdata,
  output status_t    status,
  output logic       fpga_owns_flash
);

  // bus owner register, host owns after reset
  always_ff @(posedge flash_mem_interface_done or negedge camera_1_FV) begin
    if (!camera_1_FV) begin
      fpga_owns_flash <= 1'b0;
    end else begin
      fpga_owns_flash <= take_bus;
    end
  end

  // last sr1 reply, valid from the cycle after engine_done
  always_ff @(posedge flash_mem_interface_done) begin
    if (engine_done) begin
      status <= engine_rdata;
    end
  end

  // outgoing lines from whoever owns the bus
  assign flash_spi = fpga_owns_flash ? engine_spi : host_spi;

  // miso only to the owner
  assign host_miso   = fpga_owns_flash ? 1'b0 : flash_so;
  assign engine_miso = fpga_owns_flash ? flash_so : 1'b0;

endmodule

/* capture_sequencer.sv */
module capture_sequencer
  import capture_pkg::*;
  import flash_pkg::*;
(
  input  logic        flash_mem_interface_done,
  input  logic        camera_1_FV,
  input  logic        host_rx_valid,
  input  pixel_byte_t host_rx_byte,
  input  logic        frame_valid,
  input  status_t     status,
  input  logic        engine_done,
  input  byte_count_t fifo_count,
  input  byte_count_t page_len,
  input  logic        last_page,
  input  logic        last_line,
  input  logic        last_phase,
  output cmd_req_t    cmd,
  output logic        take_bus,
  output logic        page_done,
  output logic        capture_start,
  output logic        select_enable,
  output logic        capture_busy,
  output logic        led_frame_wait,
  output logic        led_write
);

  seq_state_t state;
  seq_state_t next_state;
  logic       fv_q;
  logic       fv_rise;
  logic       fv_fall;
  logic       trigger;
  logic       phase_end;

  assign trigger   = host_rx_valid && (host_rx_byte == take_picture_code);
  assign fv_rise   = frame_valid && !fv_q;
  assign fv_fall   = !frame_valid && fv_q;
  // last page of the last line of this phase
  assign phase_end = last_page && last_line;

  always_comb begin
    next_state = state;
    case (state)
      idle:            if (trigger) next_state = wip_wait_poll;
      // one quiet cycle between status polls
      wip_wait_poll:   next_state = wip_poll;
      wip_poll:        if (engine_done) next_state = wip_check;
      wip_check:       next_state = status[sr_wip_bit] ? wip_wait_poll : wait_frame;
      // each phase starts on a fresh frame
      wait_frame:      if (fv_rise) next_state = wren;
      wren:            if (engine_done) next_state = wel_poll;
      wel_poll:        if (engine_done) next_state = wel_check;
      wel_check:       next_state = status[sr_wel_bit] ? page_ready_wait : wel_poll;
      // whole page must be buffered before pp3 starts
      page_ready_wait: if (fifo_count >= page_len) next_state = page_program;
      page_program:    if (engine_done) next_state = pp_poll;
      pp_poll:         if (engine_done) next_state = pp_check;
      pp_check:        next_state = status[sr_wip_bit] ? pp_poll : advance;
      advance: begin
        // decided on counter values before the page_done step
        if (phase_end && last_phase) begin
          next_state = idle;
        end else if (phase_end) begin
          next_state = wait_frame;
        end else begin
          next_state = wren;
        end
      end
      default:         next_state = idle;
    endcase
  end

  always_ff @(posedge flash_mem_interface_done or negedge camera_1_FV) begin
    if (!camera_1_FV) begin
      state         <= idle;
      fv_q          <= 1'b0;
      select_enable <= 1'b0;
    end else begin
      state <= next_state;
      fv_q  <= frame_valid;
      // open the line selector for exactly one frame per phase
      if (state == wait_frame && fv_rise) begin
        select_enable <= 1'b1;
      end else if (fv_fall) begin
        select_enable <= 1'b0;
      end else if (state == advance && phase_end) begin
        select_enable <= 1'b0;
      end
    end
  end

  // command levels straight from the state register
  always_comb begin
    cmd       = '0;
    cmd.wren  = (state == wren);
    cmd.rdsr1 = (state == wip_poll) || (state == wel_poll) || (state == pp_poll);
    cmd.pp3   = (state == page_program);
  end

  assign capture_busy   = (state != idle);
  // ownership request goes up with the trigger itself
  assign take_bus       = capture_busy || trigger;
  assign capture_start  = (state == idle) && trigger;
  assign page_done      = (state == advance);
  assign led_frame_wait = (state == wait_frame);
  assign led_write      = (state == page_program);

  // engine sees one command at a time
  a_cmd_onehot : assert property (
    @(posedge flash_mem_interface_done) disable iff (!camera_1_FV)
    $onehot0(cmd)
  );

  // write enable only once the latest sr1 reply showed the flash ready
  a_wren_when_ready : assert property (
    @(posedge flash_mem_interface_done) disable iff (!camera_1_FV)
    $rose(cmd.wren) |-> !status[sr_wip_bit]
  );

endmodule

/* capture_progress.sv */
module capture_progress
  import capture_pkg::*;
#(
  parameter int page_bytes      = 512,
  parameter int line_bytes      = 2592,
  parameter int lines_per_phase = 243,
  parameter int num_phases      = 8
) (
  input  logic        flash_mem_interface_done,
  input  logic        camera_1_FV,
  input  logic        capture_start,
  input  logic        page_done,
  output flash_addr_t flash_addr,
  output byte_count_t page_len,
  output phase_idx_t  phase,
  output logic        last_page,
  output logic        last_line,
  output logic        last_phase
);

  // pages per line, last one may be short
  localparam int pages_per_line = (line_bytes + page_bytes - 1) / page_bytes;
  localparam int tail_bytes     = line_bytes - (pages_per_line - 1) * page_bytes;

  page_idx_t page_idx;
  line_idx_t line_idx;

  assign last_page  = (page_idx == page_idx_t'(pages_per_line - 1));
  assign last_line  = (line_idx == line_idx_t'(lines_per_phase - 1));
  assign last_phase = (phase == phase_idx_t'(num_phases - 1));
  assign page_len   = last_page ? byte_count_t'(tail_bytes) : byte_count_t'(page_bytes);

  always_ff @(posedge flash_mem_interface_done or negedge camera_1_FV) begin
    if (!camera_1_FV) begin
      flash_addr <= '0;
      page_idx   <= '0;
      line_idx   <= '0;
      phase      <= '0;
    end else if (capture_start) begin
      flash_addr <= '0;
      page_idx   <= '0;
      line_idx   <= '0;
      phase      <= '0;
    end else if (page_done) begin
      // one page step per program, no gaps between lines or phases
      flash_addr <= flash_addr + flash_addr_t'(page_bytes);
      if (!last_page) begin
        page_idx <= page_idx + 1'b1;
      end else begin
        page_idx <= '0;
        if (!last_line) begin
          line_idx <= line_idx + 1'b1;
        end else begin
          line_idx <= '0;
          phase    <= last_phase ? '0 : phase + 1'b1;
        end
      end
    end
  end

endmodule

/* line_selector.sv */
module line_selector
  import capture_pkg::*;
#(
  parameter int num_phases = 8
) (
  input  logic        flash_mem_interface_done,
  input  logic        camera_1_FV,
  input  logic        frame_valid,
  input  logic        line_valid,
  input  logic        pixel_valid,
  input  logic [11:0] pixel_in,
  input  logic        select_enable,
  input  phase_idx_t  phase,
  output logic        push,
  output pixel_byte_t push_data
);

  logic       lv_q;
  logic       line_end;
  // frame line index modulo num_phases
  phase_idx_t line_slot;
  logic       take;

  assign line_end = lv_q && !line_valid;
  // line p + k*num_phases belongs to phase p
  assign take = select_enable && frame_valid && line_valid && pixel_valid
                && (line_slot == phase);

  always_ff @(posedge flash_mem_interface_done or negedge camera_1_FV) begin
    if (!camera_1_FV) begin
      lv_q      <= 1'b0;
      line_slot <= '0;
      push      <= 1'b0;
    end else begin
      lv_q <= line_valid;
      push <= take;
      // count restarts between frames
      if (!frame_valid) begin
        line_slot <= '0;
      end else if (line_end) begin
        line_slot <= (line_slot == phase_idx_t'(num_phases - 1)) ? '0 : line_slot + 1'b1;
      end
    end
  end

  // drop the four low bits of the pixel
  always_ff @(posedge flash_mem_interface_done) begin
    push_data <= pixel_in[11:4];
  end

endmodule

/* pixel_fifo.sv */
module pixel_fifo
  import capture_pkg::*;
#(
  parameter int depth = 2592
) (
  input  logic        flash_mem_interface_done,
  input  logic        camera_1_FV,
  input  logic        push,
  input  pixel_byte_t push_data,
  input  logic        pop,
  output pixel_byte_t pop_data,
  output byte_count_t count
);

  localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;

  pixel_byte_t      mem [depth];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;

  always_ff @(posedge flash_mem_interface_done) begin
    if (push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  // head byte visible in the cycle of the pop
  assign pop_data = mem[rd_ptr];

  always_ff @(posedge flash_mem_interface_done or negedge camera_1_FV) begin
    if (!camera_1_FV) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // depth need not be a power of two
      if (push) begin
        wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // camera side must never outrun one buffered line
  a_no_overflow : assert property (
    @(posedge flash_mem_interface_done) disable iff (!camera_1_FV)
    push |-> (count != byte_count_t'(depth))
  );

  // engine byte requests only against buffered data
  a_no_underflow : assert property (
    @(posedge flash_mem_interface_done) disable iff (!camera_1_FV)
    pop |-> (count != '0)
  );

endmodule

/* capture_top.sv */
module capture_top
  import capture_pkg::*;
  import flash_pkg::*;
#(
  parameter int page_bytes      = 512,
  parameter int line_bytes      = 2592,
  parameter int lines_per_phase = 243,
  parameter int num_phases      = 8
) (
  input  logic        flash_mem_interface_done,
  input  logic        camera_1_FV,
  input  logic        host_rx_valid,
  input  pixel_byte_t host_rx_byte,
  input  spi_lines_t  host_spi,
  output logic        host_miso,
  input  logic        frame_valid,
  input  logic        line_valid,
  input  logic        pixel_valid,
  input  logic [11:0] pixel_in,
  input  spi_lines_t  engine_spi,
  output spi_lines_t  flash_spi,
  input  logic        flash_so,
  output logic        engine_miso,
  output cmd_req_t    cmd,
  output flash_addr_t flash_addr,
  output byte_count_t num_bytes,
  output pixel_byte_t flash_wdata,
  input  logic        engine_done,
  input  logic        engine_byte_req,
  input  status_t     engine_rdata,
  output logic        capture_busy,
  output logic        fpga_owns_flash,
  output logic        led_frame_wait,
  output logic        led_write
);

  logic        take_bus;
  status_t     status;
  byte_count_t fifo_count;
  logic        last_page;
  logic        last_line;
  logic        last_phase;
  logic        page_done;
  logic        capture_start;
  logic        select_enable;
  phase_idx_t  phase;
  logic        push;
  pixel_byte_t push_data;

  flash_bus_arbiter u_arbiter (
    .flash_mem_interface_done (flash_mem_interface_done),
    .camera_1_FV              (camera_1_FV),
    .take_bus                 (take_bus),
    .host_spi                 (host_spi),
    .engine_spi               (engine_spi),
    .flash_so                 (flash_so),
    .flash_spi                (flash_spi),
    .host_miso                (host_miso),
    .engine_miso              (engine_miso),
    .engine_done              (engine_done),
    .engine_rdata             (engine_rdata),
    .status                   (status),
    .fpga_owns_flash          (fpga_owns_flash)
  );

  capture_sequencer u_sequencer (
    .flash_mem_interface_done (flash_mem_interface_done),
    .camera_1_FV              (camera_1_FV),
    .host_rx_valid            (host_rx_valid),
    .host_rx_byte             (host_rx_byte),
    .frame_valid              (frame_valid),
    .status                   (status),
    .engine_done              (engine_done),
    .fifo_count               (fifo_count),
    .page_len                 (num_bytes),
    .last_page                (last_page),
    .last_line                (last_line),
    .last_phase               (last_phase),
    .cmd                      (cmd),
    .take_bus                 (take_bus),
    .page_done                (page_done),
    .capture_start            (capture_start),
    .select_enable            (select_enable),
    .capture_busy             (capture_busy),
    .led_frame_wait           (led_frame_wait),
    .led_write                (led_write)
  );

  // page length doubles as the pp3 byte count
  capture_progress #(
    .page_bytes      (page_bytes),
    .line_bytes      (line_bytes),
    .lines_per_phase (lines_per_phase),
    .num_phases      (num_phases)
  ) u_progress (
    .flash_mem_interface_done (flash_mem_interface_done),
    .camera_1_FV              (camera_1_FV),
    .capture_start            (capture_start),
    .page_done                (page_done),
    .flash_addr               (flash_addr),
    .page_len                 (num_bytes),
    .phase                    (phase),
    .last_page                (last_page),
    .last_line                (last_line),
    .last_phase               (last_phase)
  );

  line_selector #(
    .num_phases (num_phases)
  ) u_selector (
    .flash_mem_interface_done (flash_mem_interface_done),
    .camera_1_FV              (camera_1_FV),
    .frame_valid              (frame_valid),
    .line_valid               (line_valid),
    .pixel_valid              (pixel_valid),
    .pixel_in                 (pixel_in),
    .select_enable            (select_enable),
    .phase                    (phase),
    .push                     (push),
    .push_data                (push_data)
  );

  // one line of buffering, engine byte requests pop directly
  pixel_fifo #(
    .depth (line_bytes)
  ) u_fifo (
    .flash_mem_interface_done (flash_mem_interface_done),
    .camera_1_FV              (camera_1_FV),
    .push                     (push),
    .push_data                (push_data),
    .pop                      (engine_byte_req),
    .pop_data                 (flash_wdata),
    .count                    (fifo_count)
  );

endmodule

/* flash_engine_model.sv */
module flash_engine_model
  import capture_pkg::*;
  import flash_pkg::*;
#(
  parameter int max_pages      = 64,
  parameter int max_page_bytes = 16
) (
  input  logic        flash_mem_interface_done,
  input  cmd_req_t    cmd,
  input  flash_addr_t flash_addr,
  input  byte_count_t num_bytes,
  input  pixel_byte_t flash_wdata,
  output logic        engine_done,
  output logic        engine_byte_req,
  output status_t     engine_rdata,
  output logic        order_error,
  output int          pp_count
);

  timeunit 1ns;
  timeprecision 100ps;

  integer      seed;
  // polls left before wip clears
  int          wip_left;
  logic        wel;
  // a status reply has shown wel since the last pp3
  logic        wel_seen;
  // busy since a page program or the last status reply
  logic        last_busy;
  flash_addr_t pp_addr [max_pages];
  byte_count_t pp_len  [max_pages];
  pixel_byte_t pp_data [max_pages][max_page_bytes];

  // outputs move 2 ns after the edge
  task automatic step();
    @(posedge flash_mem_interface_done);
    #2;
  endtask

  // engine latency of 0 to 3 cycles
  task automatic engine_latency();
    int n;
    n = $random(seed) & 3;
    repeat (n) step();
  endtask

  task automatic flag_error(input string what);
    $display("flash model: %s", what);
    order_error = 1'b1;
  endtask

  task automatic serve_wren();
    if (last_busy) begin
      flag_error("write enable while the last status poll reported WIP");
    end
    wel = 1'b1;
  endtask

  task automatic serve_rdsr1();
    engine_rdata             = '0;
    engine_rdata[sr_wip_bit] = (wip_left != 0);
    engine_rdata[sr_wel_bit] = wel;
    last_busy                = (wip_left != 0);
    if (wel) begin
      wel_seen = 1'b1;
    end
    if (wip_left != 0) begin
      wip_left = wip_left - 1;
    end
  endtask

  task automatic serve_pp3();
    int n;
    n = int'(num_bytes);
    if (last_busy) begin
      flag_error("page program while the last status poll reported WIP");
    end
    if (!wel_seen) begin
      flag_error("page program without a status reply showing WEL");
    end
    if (pp_count >= max_pages || n > max_page_bytes) begin
      flag_error("page program log is full");
      return;
    end
    pp_addr[pp_count] = flash_addr;
    pp_len[pp_count]  = num_bytes;
    // one request pulse per byte, head byte read while the pulse is high
    for (int i = 0; i < n; i++) begin
      engine_byte_req      = 1'b1;
      pp_data[pp_count][i] = flash_wdata;
      step();
      engine_byte_req = 1'b0;
      step();
    end
    pp_count = pp_count + 1;
    wel      = 1'b0;
    wel_seen = 1'b0;
    // array programming keeps wip up for a few polls
    wip_left  = 1 + ($random(seed) & 3);
    last_busy = 1'b1;
  endtask

  initial begin
    seed            = 32'he87c_274d;
    engine_done     = 1'b0;
    engine_byte_req = 1'b0;
    engine_rdata    = '0;
    order_error     = 1'b0;
    pp_count        = 0;
    wel             = 1'b0;
    wel_seen        = 1'b0;
    // still busy from an earlier erase
    wip_left        = 2;
    last_busy       = 1'b1;
    forever begin
      step();
      engine_done = 1'b0;
      if (cmd != '0) begin
        engine_latency();
        if (cmd.wren) begin
          serve_wren();
        end else if (cmd.rdsr1) begin
          serve_rdsr1();
        end else begin
          serve_pp3();
        end
        // single done pulse per command level
        engine_done = 1'b1;
      end
    end
  end

endmodule

/* tb_capture_top.sv */
module tb_capture_top
  import capture_pkg::*;
  import flash_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  // small geometry, three pages per line with a short tail
  localparam int page_bytes      = 3;
  localparam int line_bytes      = 8;
  localparam int lines_per_phase = 2;
  localparam int num_phases      = 2;
  localparam int pages_per_line  = (line_bytes + page_bytes - 1) / page_bytes;
  localparam int tail_bytes      = (line_bytes % page_bytes == 0) ? page_bytes
                                                                  : line_bytes % page_bytes;
  localparam int total_pages     = pages_per_line * lines_per_phase * num_phases;
  localparam int frame_lines     = lines_per_phase * num_phases;
  // long blanking so the flash drains a line before the next phase line
  localparam int line_gap        = 100;
  localparam int num_rows        = 4;

  logic        flash_mem_interface_done;
  logic        camera_1_FV;
  logic        host_rx_valid;
  pixel_byte_t host_rx_byte;
  spi_lines_t  host_spi;
  logic        host_miso;
  logic        frame_valid;
  logic        line_valid;
  logic        pixel_valid;
  logic [11:0] pixel_in;
  spi_lines_t  engine_spi;
  spi_lines_t  flash_spi;
  logic        flash_so;
  logic        engine_miso;
  cmd_req_t    cmd;
  flash_addr_t flash_addr;
  byte_count_t num_bytes;
  pixel_byte_t flash_wdata;
  logic        engine_done;
  logic        engine_byte_req;
  status_t     engine_rdata;
  logic        capture_busy;
  logic        fpga_owns_flash;
  logic        led_frame_wait;
  logic        led_write;
  logic        order_error;
  int          pp_count;
  int          frame_no;
  // frame number taken by each phase, in order
  int          phase_frames [$];

  // stimulus table, one row per test
  string       row_name    [num_rows] = '{"other_byte", "capture_first",
                                          "near_miss", "capture_second"};
  pixel_byte_t row_trigger [num_rows] = '{8'h3C, take_picture_code,
                                          8'hFE, take_picture_code};
  logic        row_capture [num_rows] = '{1'b0, 1'b1, 1'b0, 1'b1};

  capture_top #(
    .page_bytes      (page_bytes),
    .line_bytes      (line_bytes),
    .lines_per_phase (lines_per_phase),
    .num_phases      (num_phases)
  ) uut (
    .flash_mem_interface_done (flash_mem_interface_done),
    .camera_1_FV              (camera_1_FV),
    .host_rx_valid            (host_rx_valid),
    .host_rx_byte             (host_rx_byte),
    .host_spi                 (host_spi),
    .host_miso                (host_miso),
    .frame_valid              (frame_valid),
    .line_valid               (line_valid),
    .pixel_valid              (pixel_valid),
    .pixel_in                 (pixel_in),
    .engine_spi               (engine_spi),
    .flash_spi                (flash_spi),
    .flash_so                 (flash_so),
    .engine_miso              (engine_miso),
    .cmd                      (cmd),
    .flash_addr               (flash_addr),
    .num_bytes                (num_bytes),
    .flash_wdata              (flash_wdata),
    .engine_done              (engine_done),
    .engine_byte_req          (engine_byte_req),
    .engine_rdata             (engine_rdata),
    .capture_busy             (capture_busy),
    .fpga_owns_flash          (fpga_owns_flash),
    .led_frame_wait           (led_frame_wait),
    .led_write                (led_write)
  );

  flash_engine_model flash_model (
    .flash_mem_interface_done (flash_mem_interface_done),
    .cmd                      (cmd),
    .flash_addr               (flash_addr),
    .num_bytes                (num_bytes),
    .flash_wdata              (flash_wdata),
    .engine_done              (engine_done),
    .engine_byte_req          (engine_byte_req),
    .engine_rdata             (engine_rdata),
    .order_error              (order_error),
    .pp_count                 (pp_count)
  );

  initial begin
    flash_mem_interface_done = 1'b0;
    forever #10 flash_mem_interface_done = ~flash_mem_interface_done;
  end

  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("Simulation failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      stop_with_failure($sformatf("mismatch %s expected 0x%0h actual 0x%0h",
                                  name, expected, actual));
    end
  endtask

  // inputs change 2 ns after the edge
  task automatic step();
    @(posedge flash_mem_interface_done);
    #2;
  endtask

  task automatic wait_owner(input logic level, input int limit, input string what);
    int n;
    n = 0;
    while (fpga_owns_flash !== level) begin
      if (n == limit) begin
        stop_with_failure($sformatf("timeout waiting for %s", what));
      end
      step();
      n++;
    end
  endtask

  task automatic wait_idle(input int limit);
    int n;
    n = 0;
    while (capture_busy !== 1'b0) begin
      if (n == limit) begin
        stop_with_failure("timeout waiting for the capture to finish");
      end
      step();
      n++;
    end
  endtask

  // generated pixel byte for one frame position
  function automatic pixel_byte_t pixel_byte(input int frame, input int line, input int idx);
    int v;
    v = frame * 64 + line * 8 + idx;
    return v[7:0];
  endfunction

  task automatic send_host_byte(input pixel_byte_t b);
    host_rx_byte  = b;
    host_rx_valid = 1'b1;
    step();
    host_rx_valid = 1'b0;
  endtask

  task automatic send_line(input int frame, input int line);
    for (int i = 0; i < line_bytes; i++) begin
      // pixel stall in mid line, junk on the bus
      if (i == 3) begin
        pixel_valid = 1'b0;
        pixel_in    = 12'hFFF;
        step();
      end
      line_valid  = 1'b1;
      pixel_valid = 1'b1;
      // low nibble is dropped by the dut
      pixel_in    = {pixel_byte(frame, line, i), 4'(i)};
      step();
    end
    line_valid  = 1'b0;
    pixel_valid = 1'b0;
    pixel_in    = '0;
    repeat (line_gap) step();
  endtask

  task automatic send_frame(input int frame);
    frame_valid = 1'b1;
    // a phase waiting for a frame takes this one
    if (led_frame_wait) begin
      phase_frames.push_back(frame);
    end
    repeat (4) step();
    for (int l = 0; l < frame_lines; l++) begin
      send_line(frame, l);
    end
    frame_valid = 1'b0;
    repeat (20) step();
  endtask

  // free running camera
  initial begin
    frame_valid = 1'b0;
    line_valid  = 1'b0;
    pixel_valid = 1'b0;
    pixel_in    = '0;
    frame_no    = 0;
    repeat (6) step();
    forever begin
      send_frame(frame_no);
      frame_no++;
    end
  end

  always @(posedge flash_mem_interface_done) begin
    if (order_error) begin
      stop_with_failure("flash model saw a command out of order");
    end
  end

  // the write led is lit for every byte of a page program
  always @(negedge flash_mem_interface_done) begin
    if (engine_byte_req) begin
      check_value("write led", 1, 32'(led_write));
    end
  end

  task automatic run_row(input int r);
    int    pp_base;
    int    ph_base;
    int    p;
    int    k;
    int    pi;
    int    len;
    string tag;
    pp_base = pp_count;
    ph_base = phase_frames.size();
    send_host_byte(row_trigger[r]);
    if (!row_capture[r]) begin
      // a real trigger takes the bus within one cycle
      repeat (2) step();
      check_value({row_name[r], " owner"}, 0, 32'(fpga_owns_flash));
      check_value({row_name[r], " busy"}, 0, 32'(capture_busy));
      check_value({row_name[r], " flash_spi"}, 32'(host_spi), 32'(flash_spi));
      check_value({row_name[r], " host_miso"}, 32'(flash_so), 32'(host_miso));
      check_value({row_name[r], " engine_miso"}, 0, 32'(engine_miso));
      check_value({row_name[r], " pages"}, pp_base, pp_count);
    end else begin
      wait_owner(1'b1, 2, "the bus takeover");
      check_value({row_name[r], " busy"}, 1, 32'(capture_busy));
      check_value({row_name[r], " flash_spi"}, 32'(engine_spi), 32'(flash_spi));
      check_value({row_name[r], " host_miso"}, 0, 32'(host_miso));
      check_value({row_name[r], " engine_miso"}, 32'(flash_so), 32'(engine_miso));
      wait_idle(20000);
      wait_owner(1'b0, 3, "the bus release");
      check_value({row_name[r], " released spi"}, 32'(host_spi), 32'(flash_spi));
      check_value({row_name[r], " released engine_miso"}, 0, 32'(engine_miso));
      check_value({row_name[r], " leds"}, 0, 32'({led_frame_wait, led_write}));
      // the last program was polled until wip cleared
      check_value({row_name[r], " flash ready"}, 0, 32'(flash_model.last_busy));
      check_value({row_name[r], " pages"}, total_pages, pp_count - pp_base);
      check_value({row_name[r], " phases"}, num_phases, phase_frames.size() - ph_base);
      // page g maps to phase p, phase line k, page pi of the line
      for (int g = 0; g < total_pages; g++) begin
        p   = g / (pages_per_line * lines_per_phase);
        k   = (g / pages_per_line) % lines_per_phase;
        pi  = g % pages_per_line;
        len = (pi == pages_per_line - 1) ? tail_bytes : page_bytes;
        tag = $sformatf("%s page %0d", row_name[r], g);
        check_value({tag, " address"}, g * page_bytes, flash_model.pp_addr[pp_base + g]);
        check_value({tag, " length"}, len, flash_model.pp_len[pp_base + g]);
        for (int b = 0; b < len; b++) begin
          check_value($sformatf("%s byte %0d", tag, b),
                      32'(pixel_byte(phase_frames[ph_base + p], p + k * num_phases,
                                     pi * page_bytes + b)),
                      32'(flash_model.pp_data[pp_base + g][b]));
        end
      end
    end
  endtask

  initial begin
    camera_1_FV   = 1'b0;
    host_rx_valid = 1'b0;
    host_rx_byte  = '0;
    host_spi      = 3'b101;
    engine_spi    = 3'b010;
    flash_so      = 1'b1;
    repeat (4) @(posedge flash_mem_interface_done);
    #2;
    camera_1_FV = 1'b1;
    check_value("reset owner", 0, 32'(fpga_owns_flash));
    check_value("reset busy", 0, 32'(capture_busy));
    check_value("reset cmd", 0, 32'(cmd));
    check_value("reset leds", 0, 32'({led_frame_wait, led_write}));
    check_value("reset flash_spi", 32'(host_spi), 32'(flash_spi));
    for (int r = 0; r < num_rows; r++) begin
      run_row(r);
    end
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

/* capture_top.f */
capture_pkg.sv
flash_pkg.sv
flash_bus_arbiter.sv
capture_sequencer.sv
capture_progress.sv
line_selector.sv
pixel_fifo.sv
capture_top.sv
flash_engine_model.sv
tb_capture_top.sv

/* Makefile */
# verilator build and run of the capture testbench

run: obj_dir/Vtb_capture_top
	./obj_dir/Vtb_capture_top 2>&1 | tee sim.log
	grep -q "Simulation completed successfully" sim.log

obj_dir/Vtb_capture_top: capture_top.f $(wildcard *.sv)
	verilator --binary --timing --assert --timescale 1ns/1ps \
	  --top-module tb_capture_top -f capture_top.f

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
